//--- axis_byte_if.sv
// internal byte stream link
`default_nettype none

interface axis_byte_if;

    logic [7:0] data;
    logic       valid;
    logic       last;
    logic       user;

    // buffer will store a byte offered on the next cycle
    logic       ready_early;
    // byte moves on this cycle
    logic       ready;

    modport src (
        output data, valid, last, user,
        input  ready_early, ready
    );

    modport snk (
        input  data, valid, last, user,
        output ready_early, ready
    );

endinterface

`default_nettype wire

//--- axis_out_buffer.sv
// registered stream output with skid slot
`default_nettype none

module axis_out_buffer (
    input  logic       clk,
    input  logic       rst,
    axis_byte_if.snk   stream,
    output logic [7:0] out_tdata,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,
    output logic       out_tuser
);

    logic [7:0] temp_data;
    logic       temp_valid;
    logic       temp_last;
    logic       temp_user;

    logic       out_valid_next;
    logic       temp_valid_next;
    logic       load_out;
    logic       load_temp;
    logic       temp_to_out;

    // room next cycle unless the temp slot would have to take a byte
    assign stream.ready_early = out_tready || (!temp_valid && (!out_tvalid || !stream.valid));

    always_comb begin
        out_valid_next  = out_tvalid;
        temp_valid_next = temp_valid;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;

        if (stream.ready) begin
            if (out_tready || !out_tvalid) begin
                out_valid_next = stream.valid;
                load_out       = 1'b1;
            end else begin
                // output stalled, park the byte
                temp_valid_next = stream.valid;
                load_temp       = 1'b1;
            end
        end else if (out_tready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid   <= 1'b0;
            temp_valid   <= 1'b0;
            stream.ready <= 1'b0;
        end else begin
            out_tvalid   <= out_valid_next;
            temp_valid   <= temp_valid_next;
            stream.ready <= stream.ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_tdata <= stream.data;
            out_tlast <= stream.last;
            out_tuser <= stream.user;
        end else if (temp_to_out) begin
            out_tdata <= temp_data;
            out_tlast <= temp_last;
            out_tuser <= temp_user;
        end
        if (load_temp) begin
            temp_data <= stream.data;
            temp_last <= stream.last;
            temp_user <= stream.user;
        end
    end

    // stalled output byte is held until taken
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata)));

endmodule

`default_nettype wire

//--- eth_crc_8.sv
// byte-wide crc-32 register
`default_nettype none

module eth_crc_8 (
    input  logic       clk,
    input  logic       rst,
    input  logic       init,
    input  logic       update,
    input  logic [7:0] data,
    input  logic [1:0] fcs_index,
    output logic [7:0] fcs_byte
);

    import eth_fcs_pkg::*;

    logic [31:0] crc_reg;

    // eight lsb-first shift steps for one byte
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || init) begin
            crc_reg <= crc_init;
        end else if (update) begin
            crc_reg <= crc_step(crc_reg, data);
        end
    end

    // fcs is the inverted register, low byte first
    assign fcs_byte = ~crc_reg[8*fcs_index +: 8];

    // the fsm never restarts and folds in a byte at once
    a_init_update_excl: assert property (@(posedge clk) disable iff (rst) !(init && update));

endmodule

`default_nettype wire

//--- eth_fcs_insert.f
eth_fcs_pkg.sv
fcs_ctrl_pkg.sv
axis_byte_if.sv
eth_crc_8.sv
frame_byte_counter.sv
fcs_insert_fsm.sv
axis_out_buffer.sv
eth_fcs_insert.sv
fcs_checker.sv
tb_eth_fcs_insert.sv

//--- eth_fcs_insert.sv
// ethernet fcs inserter top level
`default_nettype none

module eth_fcs_insert #(
    parameter bit enable_padding   = 1'b0,
    parameter int min_frame_length = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_tdata,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  logic       in_tlast,
    input  logic       in_tuser,
    output logic [7:0] out_tdata,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,
    output logic       out_tuser,
    output logic       busy
);

    logic       crc_init;
    logic       crc_update;
    logic [7:0] fcs_byte;
    logic       cnt_clear;
    logic       cnt_incr;
    logic       pad_needed;
    logic       fcs_done;
    logic [1:0] count_lo;

    axis_byte_if byte_stream ();

    fcs_insert_fsm #(
        .enable_padding (enable_padding)
    ) i_fsm (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (in_tdata),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .in_tuser   (in_tuser),
        .stream     (byte_stream),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .fcs_byte   (fcs_byte),
        .cnt_clear  (cnt_clear),
        .cnt_incr   (cnt_incr),
        .pad_needed (pad_needed),
        .fcs_done   (fcs_done),
        .count_lo   (count_lo),
        .busy       (busy)
    );

    // crc runs over the bytes actually sent, padding included
    eth_crc_8 i_crc (
        .clk       (clk),
        .rst       (rst),
        .init      (crc_init),
        .update    (crc_update),
        .data      (byte_stream.data),
        .fcs_index (count_lo),
        .fcs_byte  (fcs_byte)
    );

    frame_byte_counter #(
        .min_frame_length (min_frame_length)
    ) i_counter (
        .clk        (clk),
        .rst        (rst),
        .clear      (cnt_clear),
        .incr       (cnt_incr),
        .pad_needed (pad_needed),
        .fcs_done   (fcs_done),
        .count_lo   (count_lo)
    );

    axis_out_buffer i_out_buffer (
        .clk        (clk),
        .rst        (rst),
        .stream     (byte_stream),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser)
    );

endmodule

`default_nettype wire

//--- eth_fcs_pkg.sv
// ethernet framing constants
`default_nettype none

package eth_fcs_pkg;

    // reflected form of 0x04c11db7
    localparam logic [31:0] crc_poly = 32'hedb88320;

    // crc register start value
    localparam logic [31:0] crc_init = 32'hffffffff;

    // fcs length in bytes
    localparam int fcs_bytes = 4;

    // frame byte counter width
    localparam int count_width = 16;

endpackage

`default_nettype wire

//--- fcs_checker.sv
// fcs inserter output checker
`default_nettype none

module fcs_checker #(
    parameter bit enable_padding   = 1'b1,
    parameter int min_frame_length = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_tdata,
    input  logic       in_tvalid,
    input  logic       in_tready,
    input  logic       in_tlast,
    input  logic       in_tuser,
    input  logic [7:0] out_tdata,
    input  logic       out_tvalid,
    input  logic       out_tready,
    input  logic       out_tlast,
    input  logic       out_tuser,
    input  logic       busy,
    input  int         test_id,
    output int         error_count,
    output int         frames_checked,
    output int         exp_pending,
    output int         act_pending
);

    typedef logic [7:0] byte_q_t[$];

    byte_q_t    cur_frame;
    byte_q_t    exp_data;
    logic       exp_last[$];
    logic       exp_user[$];
    int         exp_test[$];
    byte_q_t    act_data;
    logic       act_last[$];
    logic       act_user[$];
    int         errors = 0;
    int         frames = 0;
    int         byte_index = 0;
    logic       frame_open = 1'b0;
    // good frame tail still being generated by the DUT
    logic       tail_open = 1'b0;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset_idle";
            2: return "long_frame";
            3: return "short_padded";
            4: return "user_error";
            5: return "backpressure";
            6: return "back_to_back";
            default: return "unknown";
        endcase
    endfunction

    // bit-serial crc-32, lsb of each byte first, inverted result
    function automatic logic [31:0] crc32_ref(input byte_q_t bytes);
        logic [31:0] crc;
        logic        mix;
        int          i;
        int          b;
        crc = 32'hffffffff;
        for (i = 0; i < bytes.size(); i++) begin
            for (b = 0; b < 8; b++) begin
                mix = crc[0] ^ bytes[i][b];
                crc = crc >> 1;
                if (mix) begin
                    crc = crc ^ 32'hedb88320;
                end
            end
        end
        return ~crc;
    endfunction

    // payload, zero pad to minimum less fcs, then fcs low byte first
    function automatic byte_q_t expected_frame(input byte_q_t payload, input logic bad);
        byte_q_t     frame;
        logic [31:0] fcs;
        int          k;
        frame = payload;
        if (!bad) begin
            while (enable_padding && frame.size() < min_frame_length - 4) begin
                frame.push_back(8'h00);
            end
            fcs = crc32_ref(frame);
            for (k = 0; k < 4; k++) begin
                frame.push_back(fcs[8*k +: 8]);
            end
        end
        return frame;
    endfunction

    task automatic queue_expected(input byte_q_t payload, input logic bad);
        byte_q_t frame;
        int      k;
        frame = expected_frame(payload, bad);
        for (k = 0; k < frame.size(); k++) begin
            exp_data.push_back(frame[k]);
            exp_last.push_back(k == frame.size() - 1);
            exp_user.push_back(bad && (k == frame.size() - 1));
            exp_test.push_back(test_id);
        end
    endtask

    task automatic compare_pending();
        logic [7:0] ed;
        logic [7:0] ad;
        logic       el;
        logic       al;
        logic       eu;
        logic       au;
        string      name;
        while (exp_data.size() > 0 && act_data.size() > 0) begin
            ed = exp_data.pop_front();
            el = exp_last.pop_front();
            eu = exp_user.pop_front();
            name = test_name(exp_test.pop_front());
            ad = act_data.pop_front();
            al = act_last.pop_front();
            au = act_user.pop_front();
            if (ad !== ed) begin
                errors++;
                $display("** Error [%s] frame %0d byte %0d data: expected 0x%02h, actual 0x%02h",
                         name, frames, byte_index, ed, ad);
            end
            if (al !== el) begin
                errors++;
                $display("** Error [%s] frame %0d byte %0d tlast: expected %0b, actual %0b",
                         name, frames, byte_index, el, al);
            end
            if (au !== eu) begin
                errors++;
                $display("** Error [%s] frame %0d byte %0d tuser: expected %0b, actual %0b",
                         name, frames, byte_index, eu, au);
            end
            if (el) begin
                frames++;
                byte_index = 0;
            end else begin
                byte_index++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (frame_open && busy !== 1'b1) begin
                errors++;
                $display("** Error [%s] busy inside frame: expected 1, actual %0b",
                         test_name(test_id), busy);
            end
            if (tail_open && busy === 1'b1 && in_tready !== 1'b0) begin
                errors++;
                $display("** Error [%s] in_tready in fcs tail: expected 0, actual %0b",
                         test_name(test_id), in_tready);
            end
            // busy drops once the final fcs byte sits in the output buffer
            if (tail_open && busy !== 1'b1) begin
                if (exp_data.size() < 1 || exp_data.size() > 2) begin
                    errors++;
                    $display("** Error [%s] bytes held at busy drop: expected 1 to 2, actual %0d",
                             test_name(test_id), exp_data.size());
                end
                tail_open = 1'b0;
            end

            if (in_tvalid && in_tready) begin
                cur_frame.push_back(in_tdata);
                if (in_tlast) begin
                    queue_expected(cur_frame, in_tuser);
                    cur_frame.delete();
                    frame_open = 1'b0;
                    tail_open  = !in_tuser;
                end else begin
                    frame_open = 1'b1;
                end
            end

            if (out_tvalid && out_tready) begin
                act_data.push_back(out_tdata);
                act_last.push_back(out_tlast);
                act_user.push_back(out_tuser);
            end

            compare_pending();
        end
        error_count    <= errors;
        frames_checked <= frames;
        exp_pending    <= exp_data.size() + cur_frame.size();
        act_pending    <= act_data.size();
    end

endmodule

`default_nettype wire

//--- fcs_ctrl_pkg.sv
// fcs inserter control types
`default_nettype none

package fcs_ctrl_pkg;

    // inserter states
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_payload = 2'd1,
        st_pad     = 2'd2,
        st_fcs     = 2'd3
    } fcs_state_e;

    // source of the byte handed to the output buffer
    typedef enum logic [1:0] {
        sel_input = 2'd0,
        sel_zero  = 2'd1,
        sel_fcs   = 2'd2
    } out_sel_e;

endpackage

`default_nettype wire

//--- fcs_insert_fsm.sv
// fcs insertion state machine
`default_nettype none

module fcs_insert_fsm #(
    parameter bit enable_padding = 1'b0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic [7:0]     in_tdata,
    input  logic           in_tvalid,
    output logic           in_tready,
    input  logic           in_tlast,
    input  logic           in_tuser,
    axis_byte_if.src       stream,
    output logic           crc_init,
    output logic           crc_update,
    input  logic [7:0]     fcs_byte,
    output logic           cnt_clear,
    output logic           cnt_incr,
    input  logic           pad_needed,
    input  logic           fcs_done,
    input  logic [1:0]     count_lo,
    output logic           busy
);

    import fcs_ctrl_pkg::*;

    fcs_state_e state;
    fcs_state_e state_next;
    out_sel_e   sel;
    logic       in_tready_next;
    logic       in_fire;

    assign in_fire = in_tvalid && in_tready;

    always_comb begin
        state_next     = state;
        sel            = sel_input;
        stream.valid   = 1'b0;
        stream.last    = 1'b0;
        stream.user    = 1'b0;
        in_tready_next = 1'b0;
        crc_init       = 1'b0;
        crc_update     = 1'b0;
        cnt_clear      = 1'b0;
        cnt_incr       = 1'b0;

        case (state)
            st_idle, st_payload: begin
                in_tready_next = stream.ready_early;
                stream.valid   = in_fire;
                if (in_fire) begin
                    if (in_tlast && in_tuser) begin
                        // bad frame, pass the end through and drop the crc
                        stream.last = 1'b1;
                        stream.user = 1'b1;
                        crc_init    = 1'b1;
                        cnt_clear   = 1'b1;
                        state_next  = st_idle;
                    end else begin
                        crc_update = 1'b1;
                        if (!in_tlast) begin
                            cnt_incr   = 1'b1;
                            state_next = st_payload;
                        end else if (enable_padding && pad_needed) begin
                            in_tready_next = 1'b0;
                            cnt_incr       = 1'b1;
                            state_next     = st_pad;
                        end else begin
                            in_tready_next = 1'b0;
                            cnt_clear      = 1'b1;
                            state_next     = st_fcs;
                        end
                    end
                end
            end
            st_pad: begin
                sel          = sel_zero;
                stream.valid = 1'b1;
                if (stream.ready) begin
                    crc_update = 1'b1;
                    if (pad_needed) begin
                        cnt_incr = 1'b1;
                    end else begin
                        cnt_clear  = 1'b1;
                        state_next = st_fcs;
                    end
                end
            end
            st_fcs: begin
                sel          = sel_fcs;
                stream.valid = 1'b1;
                if (stream.ready) begin
                    if (fcs_done) begin
                        stream.last    = 1'b1;
                        crc_init       = 1'b1;
                        cnt_clear      = 1'b1;
                        in_tready_next = stream.ready_early;
                        state_next     = st_idle;
                    end else begin
                        cnt_incr = 1'b1;
                    end
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // byte source mux
    always_comb begin
        case (sel)
            sel_zero: stream.data = 8'd0;
            sel_fcs:  stream.data = fcs_byte;
            default:  stream.data = in_tdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            in_tready <= 1'b0;
            busy      <= 1'b0;
        end else begin
            state     <= state_next;
            in_tready <= in_tready_next;
            busy      <= (state_next != st_idle);
        end
    end

    // input stays stalled while padding and fcs are generated
    a_no_input_in_tail: assert property (@(posedge clk) disable iff (rst)
        (state == st_pad || state == st_fcs) |-> !in_tready);

    // fcs readout starts from the low crc byte
    a_fcs_start_index: assert property (@(posedge clk) disable iff (rst)
        (state != st_fcs && state_next == st_fcs) |=> (count_lo == 2'd0));

endmodule

`default_nettype wire

//--- frame_byte_counter.sv
// frame byte counter
`default_nettype none

module frame_byte_counter #(
    parameter int min_frame_length = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       incr,
    output logic       pad_needed,
    output logic       fcs_done,
    output logic [1:0] count_lo
);

    import eth_fcs_pkg::*;

    // last count at which the byte now moving still leaves the frame short
    localparam int pad_limit = min_frame_length - fcs_bytes - 1;

    logic [count_width-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count <= '0;
        end else if (incr) begin
            count <= count + 1'b1;
        end
    end

    // frame still under minimum after the current byte
    assign pad_needed = (count < count_width'(pad_limit));

    // counter restarts at fcs entry, so fcs_bytes-1 is the final fcs byte
    assign fcs_done = (count == count_width'(fcs_bytes - 1));

    assign count_lo = count[1:0];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the fcs inserter testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_eth_fcs_insert \
    -f eth_fcs_insert.f \
    -Mdir obj_dir -o tb_eth_fcs_insert
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/tb_eth_fcs_insert > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$log"; then
    exit 1
fi
exit 0

//--- tb_eth_fcs_insert.sv
// ethernet fcs inserter testbench
`default_nettype none

module tb_eth_fcs_insert;

    typedef logic [7:0] byte_q_t[$];

    localparam int min_len      = 64;
    localparam int reset_cycles = 5;
    localparam int idle_cycles  = 20;
    localparam int long_len     = 100;
    localparam int short_len    = 10;
    localparam int user_len     = 30;
    localparam int rand_frames  = 20;
    localparam int b2b_frames   = 5;
    localparam int frame_total  = 3 + rand_frames + b2b_frames;

    logic       clk = 1'b0;
    logic       rst;
    logic [7:0] in_tdata;
    logic       in_tvalid;
    logic       in_tready;
    logic       in_tlast;
    logic       in_tuser;
    logic [7:0] out_tdata;
    logic       out_tvalid;
    logic       out_tready = 1'b0;
    logic       out_tlast;
    logic       out_tuser;
    logic       busy;

    integer     seed;
    int         test_id;
    int         tb_errors = 0;
    int         cycle_count = 0;
    int         cycle_limit;
    logic       backpressure = 1'b0;
    int         rand_len[rand_frames];
    logic       rand_bad[rand_frames];
    int         b2b_len[b2b_frames] = '{12, 70, 25, 59, 60};
    logic       b2b_bad[b2b_frames] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    int         checker_errors;
    int         frames_checked;
    int         exp_pending;
    int         act_pending;

    eth_fcs_insert #(
        .enable_padding   (1'b1),
        .min_frame_length (min_len)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (in_tdata),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .in_tuser   (in_tuser),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser),
        .busy       (busy)
    );

    fcs_checker #(
        .enable_padding   (1'b1),
        .min_frame_length (min_len)
    ) i_checker (
        .clk            (clk),
        .rst            (rst),
        .in_tdata       (in_tdata),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tlast       (in_tlast),
        .in_tuser       (in_tuser),
        .out_tdata      (out_tdata),
        .out_tvalid     (out_tvalid),
        .out_tready     (out_tready),
        .out_tlast      (out_tlast),
        .out_tuser      (out_tuser),
        .busy           (busy),
        .test_id        (test_id),
        .error_count    (checker_errors),
        .frames_checked (frames_checked),
        .exp_pending    (exp_pending),
        .act_pending    (act_pending)
    );

    always #5 clk = ~clk;

    // sink side, roughly three of four cycles ready under back-pressure
    always @(posedge clk) begin
        if (backpressure) begin
            out_tready <= (($random(seed) & 3) != 0);
        end else begin
            out_tready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run hung, no finish after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // bytes leaving the DUT for one input frame
    function automatic int output_length(input int len, input logic bad);
        if (bad) begin
            return len;
        end
        return ((len < min_len - 4) ? min_len - 4 : len) + 4;
    endfunction

    function automatic int run_limit();
        int total;
        int n;
        total = output_length(long_len, 1'b0) + output_length(short_len, 1'b0);
        total = total + output_length(user_len, 1'b1);
        for (n = 0; n < rand_frames; n++) begin
            total = total + output_length(rand_len[n], rand_bad[n]);
        end
        for (n = 0; n < b2b_frames; n++) begin
            total = total + output_length(b2b_len[n], b2b_bad[n]);
        end
        return 8 * total + 8 * frame_total + reset_cycles + idle_cycles;
    endfunction

    function automatic byte_q_t random_payload(input int len);
        byte_q_t q;
        int      rv;
        int      n;
        for (n = 0; n < len; n++) begin
            rv = $random(seed);
            q.push_back(rv[7:0]);
        end
        return q;
    endfunction

    task automatic check_bit(input string test, input string what,
                             input logic expected, input logic actual);
        if (actual !== expected) begin
            tb_errors++;
            $display("** Error [%s] %s: expected %0b, actual %0b", test, what, expected, actual);
        end
    endtask

    // one byte per handshake, valid held until taken
    task automatic send_frame(input byte_q_t payload, input logic bad, input logic gaps);
        int n;
        int idle;
        int rv;
        for (n = 0; n < payload.size(); n++) begin
            idle = 0;
            if (gaps) begin
                rv = $random(seed);
                if (rv[3:2] == 2'b00) begin
                    idle = 1 + int'(rv[1:0]);
                end
            end
            if (idle > 0) begin
                in_tvalid <= 1'b0;
                repeat (idle) @(posedge clk);
            end
            in_tdata  <= payload[n];
            in_tvalid <= 1'b1;
            in_tlast  <= (n == payload.size() - 1);
            in_tuser  <= bad && (n == payload.size() - 1);
            @(posedge clk);
            while (in_tready !== 1'b1) begin
                @(posedge clk);
            end
        end
        in_tvalid <= 1'b0;
        in_tlast  <= 1'b0;
        in_tuser  <= 1'b0;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (exp_pending != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        int rv;
        int n;
        seed      = 32'hf7e1;
        rst       = 1'b1;
        in_tdata  = 8'd0;
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        in_tuser  = 1'b0;
        test_id   = 1;

        // random frame lengths drawn up front so the cycle limit is known
        for (n = 0; n < rand_frames; n++) begin
            rv = $random(seed);
            rand_len[n] = 1 + ((rv & 32'h7fff) % 120);
            rand_bad[n] = (rv[20:18] == 3'd0);
        end
        cycle_limit = run_limit();

        repeat (reset_cycles) @(posedge clk);
        check_bit("reset_idle", "out_tvalid in reset", 1'b0, out_tvalid);
        check_bit("reset_idle", "in_tready in reset", 1'b0, in_tready);
        check_bit("reset_idle", "busy in reset", 1'b0, busy);
        rst <= 1'b0;
        for (n = 0; n < idle_cycles; n++) begin
            @(posedge clk);
            check_bit("reset_idle", "out_tvalid while idle", 1'b0, out_tvalid);
            check_bit("reset_idle", "busy while idle", 1'b0, busy);
        end
        if (act_pending != 0) begin
            tb_errors++;
            $display("output bytes appeared while no input was given");
        end

        test_id <= 2;
        send_frame(random_payload(long_len), 1'b0, 1'b0);
        wait_drained();

        test_id <= 3;
        send_frame(random_payload(short_len), 1'b0, 1'b0);
        wait_drained();

        test_id <= 4;
        send_frame(random_payload(user_len), 1'b1, 1'b0);
        wait_drained();

        test_id <= 5;
        backpressure <= 1'b1;
        for (n = 0; n < rand_frames; n++) begin
            send_frame(random_payload(rand_len[n]), rand_bad[n], 1'b1);
        end
        wait_drained();
        backpressure <= 1'b0;

        // next frame offered while the previous tail is still going out
        test_id <= 6;
        for (n = 0; n < b2b_frames; n++) begin
            send_frame(random_payload(b2b_len[n]), b2b_bad[n], 1'b0);
        end
        wait_drained();
        @(posedge clk);

        if (act_pending != 0) begin
            tb_errors++;
            $display("%0d output bytes came out with no matching input byte", act_pending);
        end
        if (frames_checked != frame_total) begin
            tb_errors++;
            $display("** Error [end_of_run] frames checked: expected %0d, actual %0d",
                     frame_total, frames_checked);
        end
        check_bit("end_of_run", "busy when drained", 1'b0, busy);

        $display("errors: %0d total, checker %0d, testbench %0d",
                 checker_errors + tb_errors, checker_errors, tb_errors);
        if (checker_errors + tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
